// File: design/dwnld_pkg.sv
/*
 * Download front end shared definitions
 * Menu indexes, DDR base nibble, serializer timeout and the
 * packed structs for the HPS, DDR and core programming sides
 */
package dwnld_pkg;

    // HPS menu indexes
    localparam logic [7:0] IDX_ROM          = 8'd0;
    localparam logic [7:0] IDX_MOD          = 8'd1;
    localparam logic [7:0] IDX_NVRAM        = 8'd2;
    localparam logic [7:0] IDX_CHEAT        = 8'd16;
    localparam logic [7:0] IDX_LOCK         = 8'd17;
    localparam logic [7:0] IDX_DIPSW        = 8'd254;
    localparam logic [7:0] IDX_CHEAT_STATUS = 8'd255;

    localparam logic [3:0] DDR_BASE    = 4'd3;   // ROM image sits at 0x3000_0000
    localparam logic [5:0] SER_TIMEOUT = 6'h3f;  // Byte advances without ready after this

    typedef struct packed {
        logic        wr;     // One-cycle strobe
        logic [7:0]  index;
        logic [26:0] addr;
        logic [7:0]  dout;
    } hps_wr_t;

    typedef struct packed {
        logic        rd;
        logic [7:0]  burstcnt;
        logic [28:0] addr;   // 64-bit word address
    } ddr_req_t;

    typedef struct packed {
        logic        busy;
        logic [63:0] dout;
        logic        dout_ready;
    } ddr_rsp_t;

    typedef struct packed {
        logic        rom_wr;
        logic [26:0] addr;
        logic [7:0]  dout;
    } ioctl_t;

endpackage

// File: design/dwnld_cfg_regs.sv
/*
 * Configuration registers
 * Core mode, DIP switch and cheat banks written from the HPS stream
 */
module dwnld_cfg_regs import dwnld_pkg::*; #(
    parameter bit DIP_FROM_HPS = 1'b1
) (
    input  logic        clk,
    input  logic        rst,
    input  hps_wr_t     hps,
    input  logic [31:0] status,
    output logic [6:0]  core_mod,
    output logic [31:0] dipsw,
    output logic [31:0] cheat
);

    logic [3:0][7:0] dsw;
    logic [3:0][7:0] cheat_bytes;
    logic            bank_wr;    // Byte write to a 4-byte bank

    // Only the first four addresses of a bank are real
    assign bank_wr = hps.wr && hps.addr[24:2] == '0;

    assign dipsw = DIP_FROM_HPS ? dsw : status;  // OSD status or MRA bytes
    assign cheat = cheat_bytes;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            core_mod    <= 7'd1;
            dsw         <= '0;
            cheat_bytes <= '0;
        end else begin
            // Fast IO sends each byte twice, odd copy is dropped
            if (hps.wr && hps.index == IDX_MOD && !hps.addr[0])
                core_mod <= hps.dout[6:0];
            if (bank_wr && hps.index == IDX_DIPSW)
                dsw[hps.addr[1:0]] <= hps.dout;          // Byte lane from addr
            if (bank_wr && hps.index == IDX_CHEAT_STATUS)
                cheat_bytes[hps.addr[1:0]] <= hps.dout;
        end
    end

endmodule

// File: design/dwnld_ctrl.sv
/*
 * Download control
 * Tracks the HPS download window, switches to DDR mode when a ROM
 * download ends with no bytes written, and muxes the ioctl port
 */
module dwnld_ctrl import dwnld_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    hps_download,
    input  hps_wr_t hps,
    input  logic    dwnld_busy,
    input  ioctl_t  ser,
    output logic    downloading,
    output logic    ddr_mode,
    output ioctl_t  ioctl,
    output logic    ioctl_ram,
    output logic    ioctl_cheat,
    output logic    ioctl_lock
);

    logic        last_dwn;
    logic        last_busy;
    logic        wr_seen;     // ROM byte arrived in this window
    logic        ddr_act;
    logic [26:0] ddr_len;
    logic [26:0] ser_base;    // Serializer address when DDR phase began
    logic [26:0] ser_addr;
    logic        dwn_rise;
    logic        dwn_fall;
    logic        busy_fall;
    logic        ddr_end;
    logic        to_ddr;

    assign dwn_rise  = hps_download && !last_dwn;
    assign dwn_fall  = !hps_download && last_dwn;
    assign busy_fall = last_busy && !dwnld_busy;
    assign to_ddr    = dwn_fall && downloading && !wr_seen;

    // Byte count of this DDR phase
    assign ser_addr = ser.addr - ser_base;
    assign ddr_end  = ddr_act && ser_addr == ddr_len;
    // Drops as soon as the last byte is acknowledged
    assign ddr_mode = ddr_act && !ddr_end;

    always_comb begin
        if (ddr_mode) begin
            ioctl = '{rom_wr: ser.rom_wr, addr: ser_addr, dout: ser.dout};
        end else begin
            ioctl.rom_wr = hps.wr && (hps.index == IDX_ROM || hps.index == IDX_NVRAM);
            ioctl.addr   = hps.addr;
            ioctl.dout   = hps.dout;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            last_dwn    <= 1'b0;
            last_busy   <= 1'b0;
            wr_seen     <= 1'b0;
            downloading <= 1'b0;
            ddr_act     <= 1'b0;
        end else begin
            last_dwn  <= hps_download;
            last_busy <= dwnld_busy;
            if (dwn_rise && hps.index == IDX_ROM) begin
                downloading <= 1'b1;
                wr_seen     <= 1'b0;
            end else if (hps.wr && hps.index == IDX_ROM) begin
                wr_seen <= 1'b1;
            end
            if (dwn_fall && downloading && wr_seen)
                downloading <= 1'b0;                // Plain direct download
            if (to_ddr)
                ddr_act <= 1'b1;                    // ROM waits in DDR
            if (busy_fall || ddr_end) begin
                downloading <= 1'b0;
                ddr_act     <= 1'b0;
            end
        end
    end

    // HPS address at the end of the window is the ROM length
    always_ff @(posedge clk) begin
        if (to_ddr) begin
            ddr_len  <= hps.addr;
            ser_base <= ser.addr;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ioctl_ram   <= 1'b0;
            ioctl_cheat <= 1'b0;
            ioctl_lock  <= 1'b0;
        end else begin
            ioctl_ram   <= hps_download && hps.index == IDX_NVRAM;
            ioctl_cheat <= hps_download && hps.index == IDX_CHEAT;
            ioctl_lock  <= hps_download && hps.index == IDX_LOCK;
        end
    end

endmodule

// File: design/ddr_burst_fetch.sv
/*
 * DDR burst fetch
 * Reads the ROM image page by page and fills the burst buffer,
 * then hands the buffer to the serializer
 */
module ddr_burst_fetch import dwnld_pkg::*; #(
    parameter int BURST_W = 7
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               ddr_mode,
    input  logic               tx_done,
    input  ddr_rsp_t           ddr_rsp,
    output ddr_req_t           ddr_req,
    output logic               buf_we,
    output logic [BURST_W-1:0] buf_addr,
    output logic               tx_start
);

    localparam int PW = 29 - 4 - BURST_W;  // Page bits left in the word address

    logic [BURST_W-1:0] beat;
    logic [PW-1:0]      page;
    logic               rd_q;
    logic               wait_data;  // Burst in flight
    logic               beat_in;

    assign ddr_req = '{
        rd:       rd_q,
        burstcnt: 8'd1 << BURST_W,
        addr:     {DDR_BASE, page, {BURST_W{1'b0}}}
    };

    // Beats only count while DDR is not stalling
    assign beat_in  = wait_data && ddr_rsp.dout_ready && !ddr_rsp.busy;
    assign buf_we   = beat_in;
    assign buf_addr = beat;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_q      <= 1'b0;
            wait_data <= 1'b0;
            tx_start  <= 1'b0;
            beat      <= '0;
            page      <= '0;
        end else if (!ddr_rsp.busy) begin     // Busy holds everything, rd included
            if (!ddr_mode) begin
                rd_q      <= 1'b0;
                wait_data <= 1'b0;
                tx_start  <= 1'b0;
                beat      <= '0;
                page      <= '0;              // Next download starts at base
            end else if (!wait_data) begin
                tx_start <= 1'b0;
                beat     <= '0;
                // Buffer is single banked, wait for it to drain
                if (tx_done && !tx_start) begin
                    rd_q      <= 1'b1;
                    wait_data <= 1'b1;
                end
            end else begin
                rd_q <= 1'b0;
                if (ddr_rsp.dout_ready) begin
                    beat <= beat + 1'b1;
                    if (&beat) begin          // Last beat of the burst
                        wait_data <= 1'b0;
                        tx_start  <= 1'b1;
                        page      <= page + 1'b1;
                    end
                end
            end
        end
    end

endmodule

// File: design/burst_buffer_ram.sv
/*
 * Burst buffer
 * Simple dual-port 64-bit RAM holding one DDR burst
 */
module burst_buffer_ram #(
    parameter int BURST_W = 7
) (
    input  logic               clk,
    input  logic               we,
    input  logic [BURST_W-1:0] waddr,
    input  logic [63:0]        wdata,
    input  logic [BURST_W-1:0] raddr,
    output logic [63:0]        rdata
);

    logic [63:0] mem [2**BURST_W];

    always_ff @(posedge clk) begin
        if (we)
            mem[waddr] <= wdata;
        rdata <= mem[raddr];  // Data one cycle after address
    end

endmodule

// File: design/byte_serializer.sv
/*
 * Byte serializer
 * Sends the burst buffer to the core one byte at a time, LSB first,
 * pacing on prog_rdy with a timeout
 */
module byte_serializer import dwnld_pkg::*; #(
    parameter int BURST_W = 7
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               tx_start,
    input  logic               prog_rdy,
    input  logic [63:0]        rdata,
    output logic [BURST_W-1:0] raddr,
    output ioctl_t             ser,
    output logic               tx_done
);

    localparam logic [1:0] ST_READ = 2'd0;  // Word address settles
    localparam logic [1:0] ST_LOAD = 2'd1;  // RAM data valid
    localparam logic [1:0] ST_SEND = 2'd2;
    localparam logic [1:0] ST_WAIT = 2'd3;  // Wait for ready or timeout

    logic [1:0]  st;
    logic [26:0] addr;       // Byte address, never cleared between bursts
    logic [63:0] shreg;
    logic [5:0]  timeout;
    logic        we;
    logic        running;
    logic        advance;

    assign raddr   = addr[BURST_W+2:3];  // Eight bytes per word
    assign running = !tx_done && !tx_start;
    assign advance = prog_rdy || timeout == SER_TIMEOUT;
    assign ser     = '{rom_wr: we, addr: addr, dout: shreg[7:0]};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tx_done <= 1'b1;
            addr    <= '0;
            we      <= 1'b0;
            st      <= ST_READ;
            timeout <= '0;
        end else if (tx_start) begin
            tx_done <= 1'b0;
            we      <= 1'b0;
            st      <= ST_READ;
            timeout <= '0;
        end else if (!tx_done) begin
            we      <= st == ST_SEND;  // rom_wr lasts one cycle
            timeout <= st == ST_SEND ? '0 : timeout + 1'b1;
            case (st)
                ST_READ: st <= ST_LOAD;
                ST_LOAD: st <= ST_SEND;
                ST_SEND: st <= ST_WAIT;
                ST_WAIT: begin
                    if (advance) begin
                        addr <= addr + 1'b1;
                        // New word needs a read cycle
                        st   <= &addr[2:0] ? ST_READ : ST_LOAD;
                        if (&addr[BURST_W+2:0])
                            tx_done <= 1'b1;  // Buffer empty
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (running) begin
            if (st == ST_LOAD && addr[2:0] == 3'd0)
                shreg <= rdata;
            else if (st == ST_WAIT && advance)
                shreg <= shreg >> 8;     // Next byte to the bottom
        end
    end

endmodule

// File: design/dwnld_top.sv
/*
 * Download front end top level
 * Configuration registers, download control, DDR fetch,
 * burst buffer and byte serializer
 */
module dwnld_top import dwnld_pkg::*; #(
    parameter int BURST_W      = 7,
    parameter bit DIP_FROM_HPS = 1'b1
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        hps_download,
    input  hps_wr_t     hps,
    output logic        hps_wait,
    input  logic        dwnld_busy,
    input  logic        prog_rdy,
    output logic        downloading,
    output ioctl_t      ioctl,
    output logic        ioctl_ram,
    output logic        ioctl_cheat,
    output logic        ioctl_lock,
    input  logic [31:0] status,
    output logic [6:0]  core_mod,
    output logic [31:0] dipsw,
    output logic [31:0] cheat,
    output ddr_req_t    ddr_req,
    input  ddr_rsp_t    ddr_rsp
);

    logic               ddr_mode;
    logic               tx_start;
    logic               tx_done;
    logic               buf_we;
    logic [BURST_W-1:0] buf_waddr;
    logic [BURST_W-1:0] buf_raddr;
    logic [63:0]        buf_rdata;
    ioctl_t             ser;

    assign hps_wait = ddr_mode;  // HPS holds off for the whole DDR phase

    dwnld_cfg_regs #(.DIP_FROM_HPS(DIP_FROM_HPS)) u_cfg (
        .clk, .rst, .hps, .status, .core_mod, .dipsw, .cheat
    );

    dwnld_ctrl u_ctrl (
        .clk, .rst, .hps_download, .hps, .dwnld_busy, .ser,
        .downloading, .ddr_mode, .ioctl, .ioctl_ram, .ioctl_cheat, .ioctl_lock
    );

    ddr_burst_fetch #(.BURST_W(BURST_W)) u_fetch (
        .clk, .rst, .ddr_mode, .tx_done, .ddr_rsp, .ddr_req,
        .buf_we, .buf_addr(buf_waddr), .tx_start
    );

    burst_buffer_ram #(.BURST_W(BURST_W)) u_buf (
        .clk,
        .we    (buf_we),
        .waddr (buf_waddr),
        .wdata (ddr_rsp.dout),
        .raddr (buf_raddr),
        .rdata (buf_rdata)
    );

    byte_serializer #(.BURST_W(BURST_W)) u_ser (
        .clk, .rst, .tx_start, .prog_rdy,
        .rdata (buf_rdata),
        .raddr (buf_raddr),
        .ser,
        .tx_done
    );

endmodule

// File: tests/tb_clkgen.sv
/*
 * Testbench clock and reset source
 * Free-running clock, reset held for a fixed number of cycles
 */
module tb_clkgen #(
    parameter int PERIOD     = 100,
    parameter int RST_CYCLES = 8
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Released on a falling edge, away from the DUT's active edge
    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(negedge clk);
        rst = 1'b0;
    end

endmodule

// File: tests/dwnld_assert.sv
/*
 * Handshake assertions for the download front end
 * Core strobe width, DDR read pulse, hps_wait inside the download window
 */
module dwnld_assert (
    input logic clk,
    input logic rst,
    input logic rom_wr,
    input logic rd,
    input logic busy,
    input logic hps_wait,
    input logic downloading
);

    int fail_count = 0;  // Read by the checker

    a_rom_wr_pulse: assert property (@(posedge clk) disable iff (rst) rom_wr |=> !rom_wr)
        else begin
            fail_count++;
            $error("rom_wr high on two consecutive cycles");
        end

    // Read request drops once DDR has taken it
    a_rd_pulse: assert property (@(posedge clk) disable iff (rst) rd && !busy |=> !rd)
        else begin
            fail_count++;
            $error("DDR rd held after it was accepted");
        end

    a_wait_in_window: assert property (@(posedge clk) disable iff (rst) !downloading |-> !hps_wait)
        else begin
            fail_count++;
            $error("hps_wait high outside a download");
        end

endmodule

// File: tests/dwnld_checker.sv
/*
 * Download front end checker
 * Keeps a model of the config registers, index flags and DDR byte
 * stream, compares it with the DUT ports and prints the test lines
 */
module dwnld_checker import dwnld_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        hps_download,
    input  hps_wr_t     hps,
    input  logic        hps_wait,
    input  logic        downloading,
    input  ioctl_t      ioctl,
    input  logic        ioctl_ram,
    input  logic        ioctl_cheat,
    input  logic        ioctl_lock,
    input  logic [6:0]  core_mod,
    input  logic [31:0] dipsw,
    input  logic [31:0] cheat,
    input  int          test_id,
    input  int          ddr_len,     // Zero outside DDR tests
    input  logic        end_test,
    input  logic        last_test,
    input  int          assert_fails,
    output int          errors
);

    logic [6:0]      exp_mod;
    logic [3:0][7:0] exp_dsw;
    logic [3:0][7:0] exp_cht;
    logic [2:0]      exp_flags;   // ram, cheat, lock
    logic            rom_exp;
    logic            last_wait;
    int              ddr_count;   // DDR bytes seen this test
    int              test_errs;
    int              err_total;
    int              tests_run;

    assign errors = err_total + assert_fails;

    function automatic string test_name(input int id);
        case (id)
            1: return "core mode";
            2: return "DIP and cheat banks";
            3: return "direct download";
            4: return "DDR download";
            5: return "DDR download with stalls";
            default: return "unknown";
        endcase
    endfunction

    // Byte n of the image sits at DDR byte address 0x3000_0000 + n
    function automatic logic [7:0] ddr_byte(input int n);
        logic [31:0] v;
        v = (32'h3000_0000 + n) * 37;
        return v[7:0];
    endfunction

    task automatic flag_error(input string msg);
        $display("Fail at %0t: %s", $time, msg);
        test_errs++;
        err_total++;
    endtask

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            exp_mod   = 7'd1;
            exp_dsw   = '0;
            exp_cht   = '0;
            exp_flags = '0;
            last_wait = 1'b0;
            ddr_count = 0;
            test_errs = 0;
            err_total = 0;
            tests_run = 0;
        end else begin
            // Registers show writes up to the previous cycle
            if (core_mod !== exp_mod)
                flag_error($sformatf("core_mod is %0h, expected %0h", core_mod, exp_mod));
            if (dipsw !== exp_dsw)
                flag_error($sformatf("dipsw is %h, expected %h", dipsw, exp_dsw));
            if (cheat !== exp_cht)
                flag_error($sformatf("cheat is %h, expected %h", cheat, exp_cht));
            if ({ioctl_ram, ioctl_cheat, ioctl_lock} !== exp_flags)
                flag_error($sformatf("index flags are %b, expected %b",
                                     {ioctl_ram, ioctl_cheat, ioctl_lock}, exp_flags));
            if (!hps_wait) begin
                // HPS passthrough, same cycle as the strobe
                rom_exp = hps.wr && (hps.index == IDX_ROM || hps.index == IDX_NVRAM);
                if (ioctl.rom_wr !== rom_exp)
                    flag_error($sformatf("rom_wr is %b, expected %b", ioctl.rom_wr, rom_exp));
                else if (rom_exp && (ioctl.addr !== hps.addr || ioctl.dout !== hps.dout))
                    flag_error($sformatf("ioctl %0h:%h, expected %0h:%h", ioctl.addr,
                                         ioctl.dout, hps.addr, hps.dout));
                if (rom_exp && hps.index == IDX_ROM && !downloading)
                    flag_error("downloading low during a ROM write");
            end else if (ioctl.rom_wr) begin
                if (ioctl.addr !== 27'(ddr_count) || ioctl.dout !== ddr_byte(ddr_count))
                    flag_error($sformatf("DDR byte %0h:%h, expected %0h:%h", ioctl.addr,
                                         ioctl.dout, ddr_count, ddr_byte(ddr_count)));
                ddr_count++;
            end
            if (last_wait && !hps_wait && ddr_count != ddr_len)
                flag_error($sformatf("hps_wait fell after %0d of %0d bytes", ddr_count, ddr_len));
            last_wait = hps_wait;

            // Model update from this cycle's HPS strobe
            if (hps.wr && hps.index == IDX_MOD && !hps.addr[0])
                exp_mod = hps.dout[6:0];
            if (hps.wr && hps.addr[24:2] == '0) begin
                if (hps.index == IDX_DIPSW)
                    exp_dsw[hps.addr[1:0]] = hps.dout;
                if (hps.index == IDX_CHEAT_STATUS)
                    exp_cht[hps.addr[1:0]] = hps.dout;
            end
            exp_flags = {hps_download && hps.index == IDX_NVRAM,
                         hps_download && hps.index == IDX_CHEAT,
                         hps_download && hps.index == IDX_LOCK};

            if (end_test) begin
                if (ddr_len != 0 && ddr_count != ddr_len)
                    flag_error($sformatf("%0d DDR bytes seen, expected %0d", ddr_count, ddr_len));
                if (downloading || hps_wait)
                    flag_error("download still active at end of test");
                $display("Test %0d (%s) finished with %0d errors", test_id,
                         test_name(test_id), test_errs);
                tests_run++;
                test_errs = 0;
                ddr_count = 0;
                if (last_test)
                    $display("Summary: %0d tests, %0d check errors, %0d assertion failures",
                             tests_run, err_total, assert_fails);
            end
        end
    end

endmodule

// File: tests/dwnld_tb.sv
/*
 * Download front end testbench
 * Random HPS stimulus, DDR responder model, DUT, checker and timeout
 */
module dwnld_tb import dwnld_pkg::*; ();

    localparam int N_MOD  = 24;
    localparam int N_BANK = 32;

    logic        clk;
    logic        rst;
    logic        hps_download;
    hps_wr_t     hps;
    logic        hps_wait;
    logic        dwnld_busy;
    logic        prog_rdy = 1'b1;
    logic        downloading;
    ioctl_t      ioctl;
    logic        ioctl_ram;
    logic        ioctl_cheat;
    logic        ioctl_lock;
    logic [31:0] status;
    logic [6:0]  core_mod;
    logic [31:0] dipsw;
    logic [31:0] cheat;
    ddr_req_t    ddr_req;
    ddr_rsp_t    ddr_rsp = '0;

    int          test_id;
    int          ddr_len;
    logic        end_test;
    logic        last_test;
    logic        stall_mode;   // Random DDR busy and prog_rdy
    int          errors;
    int          cycle_limit = 0;
    int          cycles = 0;

    // DDR responder state
    logic        busy_n;
    logic        ready_n;
    logic [31:0] burst_addr;   // Byte address of the burst
    int          beat_k;
    int          beats_left;

    tb_clkgen #(.PERIOD(100), .RST_CYCLES(8)) clkgen_i (.clk, .rst);

    dwnld_top #(.BURST_W(3), .DIP_FROM_HPS(1'b1)) dwnld_top_i (
        .clk, .rst, .hps_download, .hps, .hps_wait, .dwnld_busy, .prog_rdy,
        .downloading, .ioctl, .ioctl_ram, .ioctl_cheat, .ioctl_lock, .status,
        .core_mod, .dipsw, .cheat, .ddr_req, .ddr_rsp
    );

    bind dwnld_top dwnld_assert hs_assert_i (
        .clk, .rst, .rom_wr(ioctl.rom_wr), .rd(ddr_req.rd), .busy(ddr_rsp.busy),
        .hps_wait, .downloading
    );

    dwnld_checker chk_i (
        .clk, .rst, .hps_download, .hps, .hps_wait, .downloading, .ioctl,
        .ioctl_ram, .ioctl_cheat, .ioctl_lock, .core_mod, .dipsw, .cheat,
        .test_id, .ddr_len, .end_test, .last_test,
        .assert_fails(dwnld_top_i.hs_assert_i.fail_count),
        .errors
    );

    // Byte i of beat k equals low byte of (A + 8k + i) * 37
    function automatic logic [63:0] ddr_word(input logic [31:0] a, input int k);
        logic [63:0] w;
        logic [31:0] b;
        for (int i = 0; i < 8; i++) begin
            b = (a + 8 * k + i) * 37;
            w[8*i +: 8] = b[7:0];
        end
        return w;
    endfunction

    // Decides this cycle's response, then tracks what the next rising edge takes
    always @(negedge clk) begin
        if (rst) begin
            beats_left = 0;
            beat_k     = 0;
        end else begin
            busy_n  = stall_mode && $urandom % 6 == 0;
            ready_n = beats_left > 0 && (!stall_mode || $urandom % 3 != 0);
            ddr_rsp = '{busy: busy_n, dout: ready_n ? ddr_word(burst_addr, beat_k) : '0,
                        dout_ready: ready_n};
            prog_rdy = !stall_mode || $urandom % 2 == 0;
            if (!busy_n) begin
                if (ready_n) begin
                    beat_k++;
                    beats_left--;
                end else if (beats_left == 0 && ddr_req.rd) begin
                    burst_addr = {ddr_req.addr, 3'b000};   // Word to byte address
                    beats_left = ddr_req.burstcnt;
                    beat_k     = 0;
                end
            end
        end
    end

    task automatic hps_write(input logic [7:0] index, input logic [26:0] addr,
                             input logic [7:0] data);
        hps = '{wr: 1'b1, index: index, addr: addr, dout: data};
        @(negedge clk);
        hps.wr = 1'b0;    // One idle cycle between strobes
        @(negedge clk);
    endtask

    task automatic direct_load(input logic [7:0] index, input int n);
        hps.index    = index;
        hps_download = 1'b1;
        @(negedge clk);
        if (index == IDX_ROM)
            while (!downloading) @(negedge clk);
        for (int a = 0; a < n; a++)
            hps_write(index, 27'(a), 8'($urandom));
        hps_download = 1'b0;
        @(negedge clk);
        while (downloading) @(negedge clk);
    endtask

    // Download window that only raises an index flag
    task automatic flag_window(input logic [7:0] index, input int n);
        hps.index    = index;
        hps_download = 1'b1;
        repeat (n) @(negedge clk);
        hps_download = 1'b0;
        repeat (2) @(negedge clk);
    endtask

    task automatic ddr_load(input int len, input logic stalls);
        ddr_len      = len;
        stall_mode   = stalls;
        hps.index    = IDX_ROM;
        hps.addr     = '0;
        hps_download = 1'b1;
        @(negedge clk);
        while (!downloading) @(negedge clk);
        hps.addr = 27'(len);             // End address is the ROM length
        @(negedge clk);
        hps_download = 1'b0;             // No byte written, ROM is in DDR
        while (!hps_wait) @(negedge clk);
        while (hps_wait || downloading) @(negedge clk);
        stall_mode = 1'b0;
        // Serializer drains the buffer tail before the next download
        while (!dwnld_top_i.tx_done) @(negedge clk);
    endtask

    task automatic finish_test(input logic last);
        end_test  = 1'b1;
        last_test = last;
        @(negedge clk);
        end_test = 1'b0;
    endtask

    initial begin
        int          n_direct;
        int          n_nvram;
        int          len_a;
        int          len_b;
        logic [26:0] bank_addr;
        void'($urandom(32'hce3a));
        hps          = '0;
        hps_download = 1'b0;
        dwnld_busy   = 1'b0;
        status       = $urandom;   // Ignored, dipsw comes from HPS bytes
        test_id      = 0;
        ddr_len      = 0;
        end_test     = 1'b0;
        last_test    = 1'b0;
        stall_mode   = 1'b0;
        n_direct     = 16 + $urandom % 33;
        n_nvram      = 4 + $urandom % 9;
        len_a        = 1 + $urandom % 256;  // Up to four 64-byte bursts
        len_b        = 1 + $urandom % 256;
        cycle_limit  = (N_MOD + N_BANK + n_direct + n_nvram + len_a + len_b) * 80 + 2000;
        @(negedge rst);
        @(negedge clk);

        test_id = 1;
        repeat (N_MOD) hps_write(IDX_MOD, 27'($urandom), 8'($urandom));
        finish_test(1'b0);

        test_id = 2;
        repeat (N_BANK) begin
            bank_addr = 27'($urandom);
            if ($urandom % 2 == 0)
                bank_addr[24:2] = '0;    // Half land inside the bank
            hps_write($urandom % 2 ? IDX_DIPSW : IDX_CHEAT_STATUS, bank_addr, 8'($urandom));
        end
        finish_test(1'b0);

        test_id = 3;
        direct_load(IDX_ROM, n_direct);
        direct_load(IDX_NVRAM, n_nvram);
        flag_window(IDX_CHEAT, 4);
        flag_window(IDX_LOCK, 4);
        finish_test(1'b0);

        test_id = 4;
        ddr_load(len_a, 1'b0);
        finish_test(1'b0);

        test_id = 5;
        ddr_load(len_b, 1'b1);
        finish_test(1'b1);

        @(negedge clk);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

    initial begin
        wait (cycle_limit != 0);
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: run did not finish within %0d cycles", cycle_limit);
        $display("Done: errors found");
        $finish;
    end

endmodule

// File: list.f
design/dwnld_pkg.sv
design/dwnld_cfg_regs.sv
design/dwnld_ctrl.sv
design/ddr_burst_fetch.sv
design/burst_buffer_ram.sv
design/byte_serializer.sv
design/dwnld_top.sv
tests/tb_clkgen.sv
tests/dwnld_assert.sv
tests/dwnld_checker.sv
tests/dwnld_tb.sv
